// File: Bender.yml
package:
  name: fetch_unit

sources:
  - source/rv_isa_pkg.sv
  - source/fetch_pkg.sv
  - source/pc_increment.sv
  - source/quick_decoder.sv
  - source/instr_cache.sv
  - source/instruction_fetch_stage.sv
  - source/fetch_unit.sv
  - target: simulation
    files:
      - sim/fetch_unit_tb.sv

// File: sim/fetch_stim.txt
// Memory image: pair count, then word address and instruction word
// Script: entry count, then op and value (0 stall cycles, 1 branch target, 2 wait pc, 3 wait bubble pc)
// Expected non-bubble PCs: count, then the PCs in fetch order
0000000B
20000000 01234524 20000001 04567805 20000002 0789AB08 20000003 0ABCDE0C
20000004 0DEF010D 20000005 11122218 20000006 13334419 20000007 1555661B
20000008 17778800 20000009 1999AA1F 2000000A 1BBBCC3B
0000000A
00000002 20000003
00000000 00000004
00000003 20000006
00000001 20000008
00000003 2000000A
00000001 20000001
00000002 20000003
00000001 20000000
00000000 00000003
00000002 20000005
00000011
20000000 20000001 20000002 20000003 20000004 20000005
20000008 20000009 20000001 20000002 20000003
20000000 20000001 20000002 20000003 20000004 20000005

// File: sim/fetch_unit_tb.sv
`default_nettype none

module fetch_unit_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int          RESET_CYCLES = 3;
   localparam logic [31:0] LCG_SEED     = 32'hc64e545a;

   logic        clk_i;
   logic        rst_i;
   logic        stall_i;
   logic        branching_i;
   logic [29:0] branch_target_i;
   logic [29:0] instr_o;
   logic [29:0] pc_o;
   logic [1:0]  branch_jump_op_o;
   logic [2:0]  imm_src_o;
   logic        mem_req_o;
   logic [29:0] mem_addr_o;
   logic        mem_valid_i;
   logic [29:0] mem_data_i;

   logic [31:0] stim [128];
   logic [29:0] mem_image [logic [29:0]];
   bit          served [logic [29:0]];
   logic [31:0] script_op [$];
   logic [31:0] script_arg [$];
   logic [29:0] expect_pc [$];
   logic [31:0] lcg_state;
   logic [29:0] prev_instr;
   logic [29:0] prev_pc;
   int          cycle_count;
   int          cycle_limit;
   int          wait_cnt;
   bit          pending;

   fetch_unit i_fetch_unit (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .stall_i(stall_i),
      .branching_i(branching_i),
      .branch_target_i(branch_target_i),
      .instr_o(instr_o),
      .pc_o(pc_o),
      .branch_jump_op_o(branch_jump_op_o),
      .imm_src_o(imm_src_o),
      .mem_req_o(mem_req_o),
      .mem_addr_o(mem_addr_o),
      .mem_valid_i(mem_valid_i),
      .mem_data_i(mem_data_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////
   task automatic fail_run(input string what);
      $display("%s", what);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic report_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
      fail_run($sformatf("[ERROR] %0d ns %s expected %h actual %h",
                         $time, name, expected, actual));
   endtask

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // Words outside the image get an R-type pattern built from the address
   function automatic logic [29:0] mem_word(input logic [29:0] addr);
      if (mem_image.exists(addr)) begin
         return mem_image[addr];
      end
      return {addr[24:0] ^ {addr[29:25], 20'h0}, 5'b01100};
   endfunction

   function automatic logic [1:0] expect_class(input logic [4:0] opc);
      case (opc)
         rv_isa_pkg::OPC_BRANCH: return rv_isa_pkg::BJ_BRANCH;
         rv_isa_pkg::OPC_JAL:    return rv_isa_pkg::BJ_JAL;
         rv_isa_pkg::OPC_JALR:   return rv_isa_pkg::BJ_JALR;
         default:                return rv_isa_pkg::BJ_NONE;
      endcase
   endfunction

   function automatic logic [2:0] expect_imm(input logic [4:0] opc);
      case (opc)
         rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_JALR:
            return rv_isa_pkg::IMM_I;
         rv_isa_pkg::OPC_STORE:                      return rv_isa_pkg::IMM_S;
         rv_isa_pkg::OPC_BRANCH:                     return rv_isa_pkg::IMM_B;
         rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC: return rv_isa_pkg::IMM_U;
         rv_isa_pkg::OPC_JAL:                        return rv_isa_pkg::IMM_J;
         default:                                    return rv_isa_pkg::IMM_SRC_NONE;
      endcase
   endfunction

   task automatic load_stim();
      int idx;
      int count;
      int script_len;
      $readmemh("sim/fetch_stim.txt", stim);
      if (stim[0] === 'x) begin
         fail_run("Stimulus file sim/fetch_stim.txt could not be read");
      end
      idx = 1;
      for (int i = 0; i < int'(stim[0]); i++) begin
         mem_image[stim[idx][29:0]] = stim[idx+1][29:0];
         idx += 2;
      end
      count = stim[idx];
      idx++;
      script_len = 0;
      for (int i = 0; i < count; i++) begin
         script_op.push_back(stim[idx]);
         script_arg.push_back(stim[idx+1]);
         script_len += (stim[idx] == 0) ? int'(stim[idx+1]) : 1;
         idx += 2;
      end
      count = stim[idx];
      idx++;
      for (int i = 0; i < count; i++) begin
         expect_pc.push_back(stim[idx+i][29:0]);
      end
      cycle_limit = script_len * 8 + RESET_CYCLES;
   endtask

   task automatic next_drive_point();
      @(posedge clk_i);
      #2;
   endtask

   task automatic run_script();
      logic [31:0] arg;
      for (int i = 0; i < script_op.size(); i++) begin
         arg = script_arg[i];
         case (script_op[i])
            0: begin
               stall_i = 1'b1;
               repeat (arg) next_drive_point();
               stall_i = 1'b0;
            end
            1: begin
               branching_i     = 1'b1;
               branch_target_i = arg[29:0];
               next_drive_point();
               branching_i     = 1'b0;
            end
            // Wait for a fetched instruction at this PC
            2: while (!(instr_o != rv_isa_pkg::INSTR_NOP && pc_o == arg[29:0]))
               next_drive_point();
            // Wait for a bubble, i.e. a miss still open on this PC
            3: while (!(instr_o == rv_isa_pkg::INSTR_NOP && pc_o == arg[29:0]))
               next_drive_point();
            default: fail_run("Unknown script operation in stimulus file");
         endcase
      end
   endtask

   task automatic check_fetch();
      logic [29:0] want_pc;
      assert (expect_pc.size() > 0)
      else fail_run("Fetched an instruction beyond the end of the expected PC list");
      want_pc = expect_pc.pop_front();
      assert (pc_o == want_pc) else report_value("pc_o", want_pc, pc_o);
      assert (instr_o == mem_word(pc_o)) else report_value("instr_o", mem_word(pc_o), instr_o);
      assert (branch_jump_op_o == expect_class(instr_o[4:0]))
      else report_value("branch_jump_op_o", expect_class(instr_o[4:0]), branch_jump_op_o);
      assert (imm_src_o == expect_imm(instr_o[4:0]))
      else report_value("imm_src_o", expect_imm(instr_o[4:0]), imm_src_o);
   endtask

   //////////////////////////////////////////////////
   // Output checker, memory model and timeout
   //////////////////////////////////////////////////
   always begin
      @(posedge clk_i);
      #1;
      if (rst_i && stall_i) begin
         assert (instr_o == prev_instr) else report_value("instr_o", prev_instr, instr_o);
         assert (pc_o == prev_pc) else report_value("pc_o", prev_pc, pc_o);
      end else if (rst_i && instr_o != rv_isa_pkg::INSTR_NOP) begin
         check_fetch();
      end else begin
         // A bubble carries no branch class and no immediate format
         assert (branch_jump_op_o == rv_isa_pkg::BJ_NONE)
         else report_value("branch_jump_op_o", rv_isa_pkg::BJ_NONE, branch_jump_op_o);
         assert (imm_src_o == rv_isa_pkg::IMM_SRC_NONE)
         else report_value("imm_src_o", rv_isa_pkg::IMM_SRC_NONE, imm_src_o);
      end
      prev_instr = instr_o;
      prev_pc    = pc_o;
   end

   always begin
      next_drive_point();
      if (!rst_i || mem_valid_i) begin
         mem_valid_i = 1'b0;
         pending     = 1'b0;
      end else if (pending) begin
         if (wait_cnt <= 1) begin
            mem_valid_i = 1'b1;
            mem_data_i  = mem_word(mem_addr_o);
         end else begin
            wait_cnt--;
         end
      end else if (mem_req_o) begin
         // Lines never get evicted here, so a repeated request is a lost hit
         assert (!served.exists(mem_addr_o))
         else fail_run($sformatf("Cache requested word %h again after its refill", mem_addr_o));
         served[mem_addr_o] = 1'b1;
         lcg_state = lcg_next(lcg_state);
         wait_cnt  = 1 + lcg_state[17:16];
         pending   = 1'b1;
      end
   end

   always begin
      @(posedge clk_i);
      cycle_count++;
      if (cycle_count > cycle_limit) begin
         fail_run($sformatf("Timeout: run still going after %0d cycles", cycle_limit));
      end
   end

   initial begin
      rst_i           = 1'b0;
      stall_i         = 1'b0;
      branching_i     = 1'b0;
      branch_target_i = '0;
      mem_valid_i     = 1'b0;
      mem_data_i      = '0;
      lcg_state       = LCG_SEED;
      cycle_count     = 0;
      cycle_limit     = 1000;
      pending         = 1'b0;
      wait_cnt        = 0;
      load_stim();
      repeat (RESET_CYCLES) @(posedge clk_i);
      #2;
      rst_i = 1'b1;
      run_script();
      if (expect_pc.size() != 0) begin
         fail_run($sformatf("%0d expected PCs were never fetched", expect_pc.size()));
      end else begin
         $display("PASS: all tests");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

   //////////////////////////////////////////////////
   // Address space
   //////////////////////////////////////////////////

   // Word addresses and instruction words both cover bits 31:2
   localparam int XLEN_W = 30;

   // Byte address 32'h8000_0000 as a word address
   localparam logic [XLEN_W-1:0] RESET_PC = 30'h2000_0000;

   //////////////////////////////////////////////////
   // Instruction cache geometry
   //////////////////////////////////////////////////

   // Direct mapped, one word per line
   localparam int CACHE_LINES = 16;
   localparam int INDEX_W     = $clog2(CACHE_LINES);

   // Everything above the index
   localparam int TAG_W = XLEN_W - INDEX_W;

endpackage

`default_nettype wire

// File: source/fetch_unit.sv
`default_nettype none

module fetch_unit (
   input  logic                         clk_i,
   input  logic                         rst_i,

   // From later pipeline stages
   input  logic                         stall_i,
   input  logic                         branching_i,
   input  logic [fetch_pkg::XLEN_W-1:0] branch_target_i,

   // To decode
   output logic [fetch_pkg::XLEN_W-1:0] instr_o,
   output logic [fetch_pkg::XLEN_W-1:0] pc_o,
   output logic [1:0]                   branch_jump_op_o,
   output logic [2:0]                   imm_src_o,

   // Memory refill port
   output logic                         mem_req_o,
   output logic [fetch_pkg::XLEN_W-1:0] mem_addr_o,
   input  logic                         mem_valid_i,
   input  logic [fetch_pkg::XLEN_W-1:0] mem_data_i
);

   logic [fetch_pkg::XLEN_W-1:0] cache_address;
   logic [fetch_pkg::XLEN_W-1:0] cache_data;
   logic                         cache_blocking_n;

   instr_cache i_instr_cache (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .addr_i(cache_address),
      .data_o(cache_data),
      .hit_o(cache_blocking_n),
      .mem_req_o(mem_req_o),
      .mem_addr_o(mem_addr_o),
      .mem_valid_i(mem_valid_i),
      .mem_data_i(mem_data_i)
   );

   instruction_fetch_stage i_instruction_fetch_stage (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .cache_data_i(cache_data),
      .cache_address_o(cache_address),
      .cache_blocking_n_i(cache_blocking_n),
      .stall_i(stall_i),
      .branching_i(branching_i),
      .branch_target_i(branch_target_i),
      .instr_o(instr_o),
      .pc_o(pc_o),
      .branch_jump_op_o(branch_jump_op_o),
      .imm_src_o(imm_src_o)
   );

endmodule

`default_nettype wire

// File: source/instr_cache.sv
`default_nettype none

module instr_cache (
   input  logic                         clk_i,
   input  logic                         rst_i,

   input  logic [fetch_pkg::XLEN_W-1:0] addr_i,
   output logic [fetch_pkg::XLEN_W-1:0] data_o,
   output logic                         hit_o,

   output logic                         mem_req_o,
   output logic [fetch_pkg::XLEN_W-1:0] mem_addr_o,
   input  logic                         mem_valid_i,
   input  logic [fetch_pkg::XLEN_W-1:0] mem_data_i
);

   //////////////////////////////////////////////////
   // Line storage
   //////////////////////////////////////////////////
   logic [fetch_pkg::CACHE_LINES-1:0] line_valid;
   logic [fetch_pkg::TAG_W-1:0]       line_tag  [fetch_pkg::CACHE_LINES];
   logic [fetch_pkg::XLEN_W-1:0]      line_data [fetch_pkg::CACHE_LINES];

   logic [fetch_pkg::INDEX_W-1:0] lookup_index;
   logic [fetch_pkg::TAG_W-1:0]   lookup_tag;
   logic [fetch_pkg::INDEX_W-1:0] refill_index;
   logic [fetch_pkg::TAG_W-1:0]   refill_tag;

   // Split of the word address into tag and index
   assign lookup_index = addr_i[fetch_pkg::INDEX_W-1:0];
   assign lookup_tag   = addr_i[fetch_pkg::XLEN_W-1:fetch_pkg::INDEX_W];
   assign refill_index = mem_addr_o[fetch_pkg::INDEX_W-1:0];
   assign refill_tag   = mem_addr_o[fetch_pkg::XLEN_W-1:fetch_pkg::INDEX_W];

   //////////////////////////////////////////////////
   // Lookup
   //////////////////////////////////////////////////
   assign hit_o  = line_valid[lookup_index] && (line_tag[lookup_index] == lookup_tag);
   assign data_o = line_data[lookup_index];

   //////////////////////////////////////////////////
   // Refill
   //////////////////////////////////////////////////

   // Valid bits and request flag
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         line_valid <= '0;
         mem_req_o  <= 1'b0;
      end else if (mem_req_o) begin
         if (mem_valid_i) begin
            line_valid[refill_index] <= 1'b1;
            mem_req_o                <= 1'b0;
         end
      end else if (!hit_o) begin
         mem_req_o <= 1'b1;
      end
   end

   // Miss address and line contents
   always_ff @(posedge clk_i) begin
      // Captured only when a new request starts
      if (!mem_req_o && !hit_o) begin
         mem_addr_o <= addr_i;
      end
      if (mem_req_o && mem_valid_i) begin
         line_tag[refill_index]  <= refill_tag;
         line_data[refill_index] <= mem_data_i;
      end
   end

   //////////////////////////////////////////////////
   // Memory port checks
   //////////////////////////////////////////////////

   // An open request keeps its address until the memory answers
   assert property (@(posedge clk_i) disable iff (!rst_i)
      mem_req_o && !mem_valid_i |=> mem_req_o && $stable(mem_addr_o))
   else $error("mem_addr_o changed while a request was open");

   // Memory answers only to an open request
   assert property (@(posedge clk_i) disable iff (!rst_i)
      mem_valid_i |-> mem_req_o)
   else $error("mem_valid_i without mem_req_o");

endmodule

`default_nettype wire

// File: source/instruction_fetch_stage.sv
`default_nettype none

module instruction_fetch_stage (
   input  logic                         clk_i,
   input  logic                         rst_i,

   input  logic [fetch_pkg::XLEN_W-1:0] cache_data_i,
   output logic [fetch_pkg::XLEN_W-1:0] cache_address_o,
   input  logic                         cache_blocking_n_i,

   input  logic                         stall_i,
   input  logic                         branching_i,
   input  logic [fetch_pkg::XLEN_W-1:0] branch_target_i,

   output logic [fetch_pkg::XLEN_W-1:0] instr_o,
   output logic [fetch_pkg::XLEN_W-1:0] pc_o,
   output logic [1:0]                   branch_jump_op_o,
   output logic [2:0]                   imm_src_o
);

   logic [fetch_pkg::XLEN_W-1:0] pc_reg;
   logic [fetch_pkg::XLEN_W-1:0] pc_next;
   logic [fetch_pkg::XLEN_W-1:0] pc_plus_one;
   logic [1:0]                   branch_jump_op;
   logic [2:0]                   imm_src;

   // Branch target wins over the sequential PC in the same cycle
   assign pc_next         = branching_i ? branch_target_i : pc_reg;
   assign cache_address_o = pc_next;

   // Carry left open, PC wrap is not handled
   pc_increment #(
      .WIDTH(fetch_pkg::XLEN_W)
   ) i_pc_increment (
      .value_i(pc_next),
      .value_o(pc_plus_one),
      .carry_o()
   );

   // Opcode sits at bits 4:0 of the word, i.e. instruction bits 6:2
   quick_decoder i_quick_decoder (
      .opcode_i(cache_data_i[4:0]),
      .branch_jump_op_o(branch_jump_op),
      .imm_src_o(imm_src)
   );

   //////////////////////////////////////////////////
   // PC register and IF/ID outputs
   //////////////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         pc_reg           <= fetch_pkg::RESET_PC;
         pc_o             <= fetch_pkg::RESET_PC;
         instr_o          <= rv_isa_pkg::INSTR_NOP;
         branch_jump_op_o <= rv_isa_pkg::BJ_NONE;
         imm_src_o        <= rv_isa_pkg::IMM_SRC_NONE;
      end else if (!stall_i) begin
         pc_o <= pc_next;
         if (cache_blocking_n_i) begin
            pc_reg           <= pc_plus_one;
            instr_o          <= cache_data_i;
            branch_jump_op_o <= branch_jump_op;
            imm_src_o        <= imm_src;
         end else begin
            // Bubble, and retry the same address next cycle
            pc_reg           <= pc_next;
            instr_o          <= rv_isa_pkg::INSTR_NOP;
            branch_jump_op_o <= rv_isa_pkg::BJ_NONE;
            imm_src_o        <= rv_isa_pkg::IMM_SRC_NONE;
         end
      end
   end

   // Back-pressure from decode freezes the IF/ID register
   assert property (@(posedge clk_i) disable iff (!rst_i)
      stall_i |=> $stable(instr_o) && $stable(pc_o))
   else $error("IF/ID outputs changed under stall");

endmodule

`default_nettype wire

// File: source/pc_increment.sv
`default_nettype none

module pc_increment #(
   parameter int WIDTH = fetch_pkg::XLEN_W
) (
   input  logic [WIDTH-1:0] value_i,
   output logic [WIDTH-1:0] value_o,
   output logic             carry_o
);

   logic [WIDTH:0] sum;

   // One extra bit catches the wrap from all ones back to zero
   assign sum = {1'b0, value_i} + {{WIDTH{1'b0}}, 1'b1};

   assign value_o = sum[WIDTH-1:0];
   assign carry_o = sum[WIDTH];

endmodule

`default_nettype wire

// File: source/quick_decoder.sv
`default_nettype none

module quick_decoder (
   input  logic [4:0] opcode_i,
   output logic [1:0] branch_jump_op_o,
   output logic [2:0] imm_src_o
);

   // Branch/jump class
   always_comb begin
      case (opcode_i)
         rv_isa_pkg::OPC_BRANCH: branch_jump_op_o = rv_isa_pkg::BJ_BRANCH;
         rv_isa_pkg::OPC_JAL:    branch_jump_op_o = rv_isa_pkg::BJ_JAL;
         rv_isa_pkg::OPC_JALR:   branch_jump_op_o = rv_isa_pkg::BJ_JALR;
         default:                branch_jump_op_o = rv_isa_pkg::BJ_NONE;
      endcase
   end

   // Immediate format
   // R-type and unknown opcodes carry no immediate
   always_comb begin
      case (opcode_i)
         rv_isa_pkg::OPC_LOAD,
         rv_isa_pkg::OPC_OP_IMM,
         rv_isa_pkg::OPC_JALR: begin
            imm_src_o = rv_isa_pkg::IMM_I;
         end
         rv_isa_pkg::OPC_STORE: begin
            imm_src_o = rv_isa_pkg::IMM_S;
         end
         rv_isa_pkg::OPC_BRANCH: begin
            imm_src_o = rv_isa_pkg::IMM_B;
         end
         rv_isa_pkg::OPC_LUI,
         rv_isa_pkg::OPC_AUIPC: begin
            imm_src_o = rv_isa_pkg::IMM_U;
         end
         rv_isa_pkg::OPC_JAL: begin
            imm_src_o = rv_isa_pkg::IMM_J;
         end
         default: begin
            imm_src_o = rv_isa_pkg::IMM_SRC_NONE;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

   //////////////////////////////////////////////////
   // Major opcodes, instruction bits 6:2
   //////////////////////////////////////////////////
   localparam logic [4:0] OPC_LOAD   = 5'b00000;
   localparam logic [4:0] OPC_OP_IMM = 5'b00100;
   localparam logic [4:0] OPC_AUIPC  = 5'b00101;
   localparam logic [4:0] OPC_STORE  = 5'b01000;
   localparam logic [4:0] OPC_OP     = 5'b01100;
   localparam logic [4:0] OPC_LUI    = 5'b01101;
   localparam logic [4:0] OPC_BRANCH = 5'b11000;
   localparam logic [4:0] OPC_JALR   = 5'b11001;
   localparam logic [4:0] OPC_JAL    = 5'b11011;

   // Branch/jump class handed to decode
   localparam logic [1:0] BJ_NONE   = 2'b00;
   localparam logic [1:0] BJ_BRANCH = 2'b01;
   localparam logic [1:0] BJ_JAL    = 2'b10;
   localparam logic [1:0] BJ_JALR   = 2'b11;

   // Immediate formats
   localparam logic [2:0] IMM_I        = 3'b000;
   localparam logic [2:0] IMM_S        = 3'b001;
   localparam logic [2:0] IMM_B        = 3'b010;
   localparam logic [2:0] IMM_U        = 3'b011;
   localparam logic [2:0] IMM_J        = 3'b100;
   localparam logic [2:0] IMM_SRC_NONE = 3'b111;

   // addi x0,x0,0 without the fixed low bits 2'b11
   localparam logic [29:0] INSTR_NOP = 30'h0000_0004;

endpackage

`default_nettype wire

// File: src.f
source/rv_isa_pkg.sv
source/fetch_pkg.sv
source/pc_increment.sv
source/quick_decoder.sv
source/instr_cache.sv
source/instruction_fetch_stage.sv
source/fetch_unit.sv
sim/fetch_unit_tb.sv
